// ==== source/rp_sample_pkg.sv ====
// Sample path definitions shared by the converter side of the design.
// Widths, single sample types and the two-channel pair structs used
// between the ADC front end, the mixer and the DAC back end.
// Import inside a module body where the types are used.

package rp_sample_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // Raw ADC pin bus per channel
  localparam int unsigned SMP_W     = 14;  // Converter sample width
  localparam int unsigned SUM_W     = 15;  // ASG plus PID before saturation

  ////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////

  // Two's complement sample as seen by scope, ASG and PID
  typedef logic signed [SMP_W-1:0] smp_t;

  // Negative slope converter code, 0 is full positive scale
  typedef logic [SMP_W-1:0] code_t;

  // Raw pin data, low two bits reserved by the 16-bit ADC
  typedef struct packed {
    logic [ADC_RAW_W-1:0] ch_a;  // Channel 1
    logic [ADC_RAW_W-1:0] ch_b;  // Channel 2
  } raw_pair_t;

  typedef struct packed {
    smp_t ch_a;  // Channel 1
    smp_t ch_b;  // Channel 2
  } smp_pair_t;

  typedef struct packed {
    code_t ch_a;  // Channel 1
    code_t ch_b;  // Channel 2
  } code_pair_t;

endpackage

// ==== source/rp_ctrl_pkg.sv ====
// Control side definitions: board configuration bits, the daisy chain
// parallel word and the heartbeat LED defaults.
// Import inside a module body where the types are used.

package rp_ctrl_pkg;

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////

  // Mode bits, formerly housekeeping registers
  typedef struct packed {
    logic digital_loop;   // ADC takes DAC-bound samples
    logic daisy_sync;     // Daisy chain in sync mode
    logic daisy_pin;      // Trigger pin enable, width only
    logic trig_from_asg;  // Trigger out from ASG, else scope
  } rp_cfg_t;

  ////////////////////////////////////////
  // Daisy chain
  ////////////////////////////////////////

  localparam int unsigned DAISY_W = 16;  // Parallel word width

  // Sent while not in sync mode
  localparam logic [DAISY_W-1:0] DAISY_IDLE_WORD = 16'h1234;

  typedef struct packed {
    logic [DAISY_W-1:0] dat;  // Parallel data
    logic               dv;   // Data valid level
  } daisy_tx_t;

  ////////////////////////////////////////
  // LEDs
  ////////////////////////////////////////

  localparam int unsigned LED_W             = 4;
  localparam int unsigned HEARTBEAT_DEFAULT = 256000000;  // Half period, cycles

endpackage

// ==== source/adc_front.sv ====
// ADC front end. Strips the reserved low bits from both raw channels,
// turns the negative slope code into two's complement and registers it.
// With digital loopback on, the DAC-bound samples are registered instead.
// One cycle from either source to adc_smp_o.

`timescale 1ns/1ps

module adc_front (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,         // Sync, active low
  input  rp_sample_pkg::raw_pair_t adc_raw_i,      // Raw pin data
  input  rp_sample_pkg::smp_pair_t loop_smp_i,     // Mixer output for loopback
  input  logic                    digital_loop_i,  // Select loopback
  output rp_sample_pkg::smp_pair_t adc_smp_o       // To scope and PID
);

  import rp_sample_pkg::*;

  smp_pair_t conv_smp;  // Converted ADC data
  smp_pair_t smp_q;

  // Keep bits 15..2, MSB as is, flip the rest
  function automatic smp_t raw_to_smp(input logic [ADC_RAW_W-1:0] raw);
    logic [SMP_W-1:0] kept;
    kept = raw[ADC_RAW_W-1 -: SMP_W];
    return smp_t'({kept[SMP_W-1], ~kept[SMP_W-2:0]});
  endfunction

  ////////////////////////////////////////
  // Conversion
  ////////////////////////////////////////

  always_comb begin
    conv_smp.ch_a = raw_to_smp(adc_raw_i.ch_a);
    conv_smp.ch_b = raw_to_smp(adc_raw_i.ch_b);
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      smp_q <= '0;                // Zero sample
    end else if (digital_loop_i) begin
      smp_q <= loop_smp_i;        // Loopback path
    end else begin
      smp_q <= conv_smp;
    end
  end

  assign adc_smp_o = smp_q;

endmodule

// ==== source/sample_mixer.sv ====
// Sample mixer. Adds the ASG and PID samples of each channel, saturates
// the sum to the 14-bit sample range and registers it.
// The result feeds the DAC back end and the ADC loopback path.

`timescale 1ns/1ps

module sample_mixer (
  input  logic                    adc_clk,
  input  logic                    rst_n_i,     // Sync, active low
  input  rp_sample_pkg::smp_pair_t asg_smp_i,  // Generator samples
  input  rp_sample_pkg::smp_pair_t pid_smp_i,  // PID samples
  output rp_sample_pkg::smp_pair_t mix_smp_o   // Saturated sum
);

  import rp_sample_pkg::*;

  smp_pair_t sat_smp;
  smp_pair_t mix_q;

  // Sum with one guard bit, clamp when guard and MSB disagree
  function automatic smp_t sat_add(input smp_t a, input smp_t b);
    logic [SUM_W-1:0] sum;
    sum = {a[SMP_W-1], a} + {b[SMP_W-1], b};  // Sign extend both
    if (sum[SUM_W-1] ^ sum[SUM_W-2]) begin
      // Negative gives -8192, positive gives 8191
      return smp_t'({sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}});
    end
    return smp_t'(sum[SMP_W-1:0]);
  endfunction

  ////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////

  always_comb begin
    sat_smp.ch_a = sat_add(asg_smp_i.ch_a, pid_smp_i.ch_a);
    sat_smp.ch_b = sat_add(asg_smp_i.ch_b, pid_smp_i.ch_b);
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      mix_q <= '0;  // Zero sample
    end else begin
      mix_q <= sat_smp;
    end
  end

  assign mix_smp_o = mix_q;

endmodule

// ==== source/dac_back.sv ====
// DAC back end. Registers the mixed samples as negative slope DAC code
// and provides the active high DAC reset, one cycle behind rst_n_i.

`timescale 1ns/1ps

module dac_back (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,     // Sync, active low
  input  rp_sample_pkg::smp_pair_t  mix_smp_i,  // Saturated samples
  output rp_sample_pkg::code_pair_t dac_code_o, // DAC data
  output logic                     dac_rst_o    // DAC reset, active high
);

  import rp_sample_pkg::*;

  code_pair_t code_q;
  logic       dac_rst_q;

  // Signed to negative slope, same bit rule as the ADC side
  function automatic code_t smp_to_code(input smp_t smp);
    return code_t'({smp[SMP_W-1], ~smp[SMP_W-2:0]});
  endfunction

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      code_q.ch_a <= smp_to_code('0);  // Midscale, 0x1FFF
      code_q.ch_b <= smp_to_code('0);
    end else begin
      code_q.ch_a <= smp_to_code(mix_smp_i.ch_a);
      code_q.ch_b <= smp_to_code(mix_smp_i.ch_b);
    end
  end

  // Follows reset with one cycle of delay
  always_ff @(posedge adc_clk) begin
    dac_rst_q <= ~rst_n_i;
  end

  assign dac_code_o = code_q;
  assign dac_rst_o  = dac_rst_q;

endmodule

// ==== source/trig_router.sv ====
// Trigger routing between the scope, the generator and the daisy chain.
// Builds the external trigger, picks the trigger that goes out and forms
// the parallel word handed to the daisy chain transmitter.
// Purely combinational.

`timescale 1ns/1ps

module trig_router (
  input  rp_ctrl_pkg::rp_cfg_t                cfg_i,           // Mode bits
  input  logic                                trig_gpio_i,     // External pin
  input  logic                                scope_trig_i,    // Scope trigger out
  input  logic                                asg_trig_i,      // ASG trigger out
  input  logic [rp_ctrl_pkg::DAISY_W-1:0]     daisy_rx_dat_i,  // Received word
  input  logic                                daisy_rx_rdy_i,  // Receiver ready
  output logic                                trig_ext_o,
  output logic                                trig_out_o,
  output rp_ctrl_pkg::daisy_tx_t              daisy_tx_o
);

  import rp_ctrl_pkg::*;

  logic daisy_trig;  // Any bit received
  logic trig_sel;

  ////////////////////////////////////////
  // Trigger selection
  ////////////////////////////////////////

  assign daisy_trig = |daisy_rx_dat_i;

  // Pin is blocked while the chain is delivering a trigger
  assign trig_ext_o = trig_gpio_i & ~(cfg_i.daisy_sync & daisy_trig);

  assign trig_sel   = cfg_i.trig_from_asg ? asg_trig_i : scope_trig_i;
  assign trig_out_o = trig_sel;

  ////////////////////////////////////////
  // Daisy transmit word
  ////////////////////////////////////////

  always_comb begin
    if (cfg_i.daisy_sync) begin
      daisy_tx_o.dat = {DAISY_W{trig_sel}};  // Trigger on every line
      daisy_tx_o.dv  = 1'b0;
    end else begin
      daisy_tx_o.dat = DAISY_IDLE_WORD;      // Fixed test pattern
      daisy_tx_o.dv  = daisy_rx_rdy_i;
    end
  end

endmodule

// ==== source/led_heartbeat.sv ====
// Heartbeat blinker. A wrapping counter toggles one LED state every
// HEARTBEAT_HALF cycles, and that state drives all LEDs together.
// LEDs are off after reset.

`timescale 1ns/1ps

module led_heartbeat #(
  parameter int unsigned HEARTBEAT_HALF = rp_ctrl_pkg::HEARTBEAT_DEFAULT  // Cycles
) (
  input  logic                          adc_clk,
  input  logic                          rst_n_i,  // Sync, active low
  output logic [rp_ctrl_pkg::LED_W-1:0] led_o
);

  import rp_ctrl_pkg::*;

  // At least one counter bit for tiny periods
  localparam int unsigned CNT_W = (HEARTBEAT_HALF > 1) ? $clog2(HEARTBEAT_HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HEARTBEAT_HALF - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             led_q;  // Shared LED state

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      led_q <= 1'b0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_q <= '0;      // Wrap
      led_q <= ~led_q;  // Toggle once per half period
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign led_o = {LED_W{led_q}};

endmodule

// ==== source/rp_analog_top.sv ====
// Top level of the sample path between converter pins and processing.
// Wires the ADC front end, the ASG plus PID mixer, the DAC back end,
// trigger routing and the heartbeat LEDs. Everything runs on adc_clk.
// ASG/PID to DAC code takes 2 cycles, raw ADC to adc_smp_o 1 cycle.

`timescale 1ns/1ps

module rp_analog_top #(
  parameter int unsigned HEARTBEAT_HALF = rp_ctrl_pkg::HEARTBEAT_DEFAULT
) (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,         // Sync, active low
  input  rp_ctrl_pkg::rp_cfg_t              cfg_i,           // Mode bits
  // ADC side
  input  rp_sample_pkg::raw_pair_t          adc_raw_i,       // Raw ADC pins
  output rp_sample_pkg::smp_pair_t          adc_smp_o,       // To scope and PID
  // Generator and PID samples
  input  rp_sample_pkg::smp_pair_t          asg_smp_i,
  input  rp_sample_pkg::smp_pair_t          pid_smp_i,
  // DAC side
  output rp_sample_pkg::code_pair_t         dac_code_o,
  output logic                              dac_rst_o,
  // Triggers
  input  logic                              trig_gpio_i,
  input  logic                              scope_trig_i,
  input  logic                              asg_trig_i,
  output logic                              trig_ext_o,
  output logic                              trig_out_o,
  // Daisy chain parallel side
  input  logic [rp_ctrl_pkg::DAISY_W-1:0]   daisy_rx_dat_i,
  input  logic                              daisy_rx_rdy_i,
  output rp_ctrl_pkg::daisy_tx_t            daisy_tx_o,
  // LEDs
  output logic [rp_ctrl_pkg::LED_W-1:0]     led_o
);

  import rp_sample_pkg::*;

  smp_pair_t mix_smp;  // Saturated sum, to DAC and loopback

  ////////////////////////////////////////
  // Sample path
  ////////////////////////////////////////

  adc_front adc_front_inst (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_raw_i      (adc_raw_i),
    .loop_smp_i     (mix_smp),           // DAC-bound sample
    .digital_loop_i (cfg_i.digital_loop),
    .adc_smp_o      (adc_smp_o)
  );

  sample_mixer sample_mixer_inst (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .asg_smp_i (asg_smp_i),
    .pid_smp_i (pid_smp_i),
    .mix_smp_o (mix_smp)
  );

  dac_back dac_back_inst (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .mix_smp_i  (mix_smp),
    .dac_code_o (dac_code_o),
    .dac_rst_o  (dac_rst_o)
  );

  ////////////////////////////////////////
  // Triggers and LEDs
  ////////////////////////////////////////

  trig_router trig_router_inst (
    .cfg_i          (cfg_i),
    .trig_gpio_i    (trig_gpio_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o),
    .daisy_tx_o     (daisy_tx_o)
  );

  led_heartbeat #(
    .HEARTBEAT_HALF (HEARTBEAT_HALF)
  ) led_heartbeat_inst (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .led_o   (led_o)
  );

endmodule

// ==== test/rp_analog_assert.sv ====
// Concurrent checks on the top level, attached with bind.
// Covers the LED group, the DAC reset timing and the daisy data
// valid level in sync mode.

`timescale 1ns/1ps

module rp_analog_assert (
  input logic                          adc_clk,
  input logic                          rst_n_i,     // Sync, active low
  input rp_ctrl_pkg::rp_cfg_t          cfg_i,
  input logic                          dac_rst_i,   // DAC reset from top
  input rp_ctrl_pkg::daisy_tx_t        daisy_tx_i,  // Daisy word from top
  input logic [rp_ctrl_pkg::LED_W-1:0] led_i
);

  import rp_ctrl_pkg::*;

  // All LEDs share one state
  led_group_a: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) led_i == {LED_W{led_i[0]}}
  ) else $error("LED outputs differ");

  // Reset cycle is followed by DAC reset high
  dac_rst_a: assert property (
    @(posedge adc_clk) !rst_n_i |=> dac_rst_i
  ) else $error("DAC reset low after a reset cycle");

  daisy_dv_a: assert property (
    @(posedge adc_clk) cfg_i.daisy_sync |-> !daisy_tx_i.dv  // Sync mode sends no data
  ) else $error("Daisy data valid high in sync mode");

endmodule

bind rp_analog_top rp_analog_assert rp_analog_assert_inst (
  .adc_clk    (adc_clk),
  .rst_n_i    (rst_n_i),
  .cfg_i      (cfg_i),
  .dac_rst_i  (dac_rst_o),
  .daisy_tx_i (daisy_tx_o),
  .led_i      (led_o)
);

// ==== test/rp_analog_tb.sv ====
// Testbench for the sample path top level. Reads stimulus and expected
// outputs from the golden vector file, holds each vector for four cycles
// and then compares every output against the file.
// Heartbeat LEDs are checked each cycle against a count taken since reset.
// Run from the project root so the vector file is found.

`timescale 1ns/1ps

module rp_analog_tb;

  import rp_sample_pkg::*;
  import rp_ctrl_pkg::*;

  localparam int unsigned CLK_HALF    = 10;                // 20 ns period
  localparam int unsigned HB_HALF     = 8;                 // Short blink for sim
  localparam int unsigned NUM_VEC     = 24;                // Lines in golden file
  localparam int unsigned VEC_FIELDS  = 15;                // Words per line
  localparam int unsigned HOLD_CYC    = 4;                 // Cycles per vector
  localparam int unsigned TIMEOUT_CYC = HOLD_CYC * NUM_VEC + 64;
  localparam int unsigned PAIR_W      = $bits(smp_pair_t);

  logic               adc_clk;
  logic               rst_n_i;
  rp_cfg_t            cfg_i;
  raw_pair_t          adc_raw_i;
  smp_pair_t          adc_smp_o;
  smp_pair_t          asg_smp_i;
  smp_pair_t          pid_smp_i;
  code_pair_t         dac_code_o;
  logic               dac_rst_o;
  logic               trig_gpio_i;
  logic               scope_trig_i;
  logic               asg_trig_i;
  logic               trig_ext_o;
  logic               trig_out_o;
  logic [DAISY_W-1:0] daisy_rx_dat_i;
  logic               daisy_rx_rdy_i;
  daisy_tx_t          daisy_tx_o;
  logic [LED_W-1:0]   led_o;

  // Field order: raw asg pid cfg gpio strig atrig rx_dat rdy, then
  // adc_smp dac_code ext out tx_dat dv
  logic [31:0] golden_mem [0:NUM_VEC*VEC_FIELDS-1];

  int unsigned cyc_cnt  = 0;
  int unsigned hb_edges = 0;  // Clock edges out of reset
  int unsigned err_cnt  = 0;

  rp_analog_top #(
    .HEARTBEAT_HALF (HB_HALF)
  ) rp_analog_top_inst (.*);

  initial begin
    adc_clk = 1'b0;
    forever #CLK_HALF adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // Failure handling and compares
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_smp_pair(input string name, input smp_pair_t got, input smp_pair_t exp);
    if (got !== exp) begin
      err_cnt++;
      stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_code_pair(input string name, input code_pair_t got,
                                 input code_pair_t exp);
    if (got !== exp) begin
      err_cnt++;
      stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_daisy_tx(input string name, input daisy_tx_t got, input daisy_tx_t exp);
    if (got !== exp) begin
      err_cnt++;
      stop_run($sformatf("Fail %s: got dat %h dv %h expected dat %h dv %h",
                         name, got.dat, got.dv, exp.dat, exp.dv));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_led(input string name, input logic [LED_W-1:0] got,
                           input logic [LED_W-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Vector handling
  ////////////////////////////////////////

  task automatic apply_vector(input int unsigned idx);
    int unsigned base;
    base           = idx * VEC_FIELDS;
    adc_raw_i      = raw_pair_t'(golden_mem[base]);
    asg_smp_i      = smp_pair_t'(golden_mem[base+1][PAIR_W-1:0]);
    pid_smp_i      = smp_pair_t'(golden_mem[base+2][PAIR_W-1:0]);
    cfg_i          = rp_cfg_t'(golden_mem[base+3][3:0]);
    trig_gpio_i    = golden_mem[base+4][0];
    scope_trig_i   = golden_mem[base+5][0];
    asg_trig_i     = golden_mem[base+6][0];
    daisy_rx_dat_i = golden_mem[base+7][DAISY_W-1:0];
    daisy_rx_rdy_i = golden_mem[base+8][0];
  endtask

  task automatic compare_vector(input int unsigned idx);
    int unsigned base;
    daisy_tx_t   exp_tx;
    base       = idx * VEC_FIELDS;
    exp_tx.dat = golden_mem[base+13][DAISY_W-1:0];
    exp_tx.dv  = golden_mem[base+14][0];
    check_smp_pair($sformatf("adc_smp_o, vector %0d", idx), adc_smp_o,
                   smp_pair_t'(golden_mem[base+9][PAIR_W-1:0]));
    check_code_pair($sformatf("dac_code_o, vector %0d", idx), dac_code_o,
                    code_pair_t'(golden_mem[base+10][PAIR_W-1:0]));
    check_bit($sformatf("trig_ext_o, vector %0d", idx), trig_ext_o, golden_mem[base+11][0]);
    check_bit($sformatf("trig_out_o, vector %0d", idx), trig_out_o, golden_mem[base+12][0]);
    check_daisy_tx($sformatf("daisy_tx_o, vector %0d", idx), daisy_tx_o, exp_tx);
    check_bit($sformatf("dac_rst_o, vector %0d", idx), dac_rst_o, 1'b0);  // Long out of reset
  endtask

  ////////////////////////////////////////
  // Heartbeat model and timeout
  ////////////////////////////////////////

  always @(posedge adc_clk) begin
    if (!rst_n_i) begin
      hb_edges <= 0;
    end else begin
      hb_edges <= hb_edges + 1;
    end
  end

  // LEDs flip after every HB_HALF edges, checked mid cycle
  always @(negedge adc_clk) begin
    if (rst_n_i) begin
      check_led("led_o", led_o, {LED_W{((hb_edges / HB_HALF) % 2) == 1}});
    end
  end

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      stop_run($sformatf("Timeout after %0d cycles, vectors did not finish", cyc_cnt));
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n_i        = 1'b0;
    cfg_i          = '0;
    adc_raw_i      = '0;
    asg_smp_i      = '0;
    pid_smp_i      = '0;
    trig_gpio_i    = 1'b0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;
    daisy_rx_dat_i = '0;
    daisy_rx_rdy_i = 1'b0;
    $readmemh("test/rp_analog_golden.txt", golden_mem);
    repeat (2) @(posedge adc_clk);  // Reset for 2 cycles
    #1;
    rst_n_i = 1'b1;
    check_bit("dac_rst_o after reset", dac_rst_o, 1'b1);  // Held one more cycle
    for (int unsigned i = 0; i < NUM_VEC; i++) begin
      apply_vector(i);
      repeat (HOLD_CYC) @(posedge adc_clk);
      #1;                // Registered outputs settled
      compare_vector(i);  // Next vector follows at the same time
    end
    if (err_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_run($sformatf("%0d compare errors recorded", err_cnt));
    end
  end

endmodule

// ==== test/rp_analog_golden.txt ====
// Columns: raw_adc asg_pair pid_pair cfg gpio scope_trig asg_trig daisy_rx rx_rdy
//          then expected adc_smp dac_code trig_ext trig_out daisy_tx_dat daisy_tx_dv
// Pairs pack ch_a above ch_b, cfg is {loop, sync, pin, from_asg}
// ADC conversion, loopback off
00000000 0000000 0000000 0 0 0 0 0000 0 7FFDFFF 7FFDFFF 0 0 1234 0
FFFFFFFF 0000000 0000000 0 0 0 0 0000 1 8002000 7FFDFFF 0 0 1234 1
80007FFF 0000000 0000000 0 0 0 0 0000 0 FFFC000 7FFDFFF 0 0 1234 0
7FFC0003 0000000 0000000 0 0 0 0 0000 0 0001FFF 7FFDFFF 0 0 1234 0
40001234 0000000 0000000 0 0 0 0 0000 0 3FFDB72 7FFDFFF 0 0 1234 0
12348001 0000000 0000000 0 0 0 0 0000 0 6DCBFFF 7FFDFFF 0 0 1234 0
// Saturating mix, loopback off
00000000 0193F9C 0000000 0 0 0 0 0000 0 7FFDFFF 7E6E063 0 0 1234 0
00000000 7FFD000 0005000 0 0 0 0 0000 0 7FFDFFF 0000000 0 0 1234 0
00000000 8003000 FFFF000 0 0 0 0 0000 0 7FFDFFF FFFFFFF 0 0 1234 0
00000000 7FFC123 FFFC456 0 0 0 0 0000 0 7FFDFFF 0005A86 0 0 1234 0
00000000 FC02001 0403FFE 0 0 0 0 0000 0 7FFDFFF 7FFFFFF 0 0 1234 0
// Digital loopback, raw input ignored
5555AAAA 0193F9C 0000000 8 0 0 0 0000 0 0193F9C 7E6E063 0 0 1234 0
80008000 7FFD000 0005000 8 0 0 0 0000 0 7FFDFFF 0000000 0 0 1234 0
FFFF0000 8003000 FFFF000 8 0 0 0 0000 0 8002000 FFFFFFF 0 0 1234 0
1234ABCD 7FFC123 FFFC456 8 0 0 0 0000 0 7FF8579 0005A86 0 0 1234 0
// Trigger routing and daisy word
00000000 0000000 0000000 0 1 1 0 0000 1 7FFDFFF 7FFDFFF 1 1 1234 1
00000000 0000000 0000000 1 1 1 0 00FF 0 7FFDFFF 7FFDFFF 1 0 1234 0
00000000 0000000 0000000 1 0 0 1 0000 1 7FFDFFF 7FFDFFF 0 1 1234 1
00000000 0000000 0000000 4 1 1 0 0000 1 7FFDFFF 7FFDFFF 1 1 FFFF 0
00000000 0000000 0000000 4 1 0 1 0001 1 7FFDFFF 7FFDFFF 0 0 0000 0
00000000 0000000 0000000 5 1 0 1 8000 0 7FFDFFF 7FFDFFF 0 1 FFFF 0
00000000 0000000 0000000 6 0 1 1 0000 1 7FFDFFF 7FFDFFF 0 1 FFFF 0
00000000 0000000 0000000 2 1 0 0 FFFF 1 7FFDFFF 7FFDFFF 1 0 1234 1
00000000 0193F9C 0000000 D 1 0 1 0000 1 0193F9C 7E6E063 1 1 FFFF 0

// ==== sim.f ====
source/rp_sample_pkg.sv
source/rp_ctrl_pkg.sv
source/adc_front.sv
source/sample_mixer.sv
source/dac_back.sv
source/trig_router.sv
source/led_heartbeat.sv
source/rp_analog_top.sv
test/rp_analog_assert.sv
test/rp_analog_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failures

TOP=rp_analog_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f sim.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation reported errors, see $LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation finished cleanly"
exit 0
